//--- hw/axil_pkg.sv
package axil_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = DATA_W / 8;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb; // One bit per byte lane
    } axil_w_t;

    typedef struct packed {
        axil_resp_t resp;
    } axil_b_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        axil_resp_t        resp;
    } axil_r_t;

endpackage

//--- hw/bus_cmd_pkg.sv
package bus_cmd_pkg;

    import axil_pkg::*;

    localparam int unsigned CMD_DEPTH = 4;
    localparam int unsigned REG_COUNT = 16; // Word addresses 0x00 to 0x3C

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_t;

    typedef struct packed {
        bus_op_t           op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } bus_cmd_t;

    typedef struct packed {
        bus_op_t           op;
        logic [DATA_W-1:0] data; // Zero for writes
        axil_resp_t        resp;
    } bus_rsp_t;

endpackage

//--- hw/cmd_queue.sv
module cmd_queue
    import bus_cmd_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cmd_valid,
    output logic     cmd_ready,
    input  bus_cmd_t cmd,
    output logic     q_valid,
    input  logic     q_ready,
    output bus_cmd_t q_cmd
);

    typedef logic [$clog2(CMD_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(CMD_DEPTH+1)-1:0] cnt_t;

    bus_cmd_t mem [CMD_DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    cnt_t     count;
    logic     push;
    logic     pop;

    assign cmd_ready = (count != cnt_t'(CMD_DEPTH));
    assign q_valid   = (count != '0);
    assign q_cmd     = mem[rd_ptr];

    assign push = cmd_valid && cmd_ready;
    assign pop  = q_valid && q_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Idle or push with pop
            endcase
        end
    end

endmodule

//--- hw/axil_master.sv
module axil_master
    import axil_pkg::*;
    import bus_cmd_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     q_valid,
    output logic     q_ready,
    input  bus_cmd_t q_cmd,
    output logic     aw_valid,
    input  logic     aw_ready,
    output axil_aw_t aw,
    output logic     w_valid,
    input  logic     w_ready,
    output axil_w_t  w,
    input  logic     b_valid,
    output logic     b_ready,
    input  axil_b_t  b,
    output logic     ar_valid,
    input  logic     ar_ready,
    output axil_ar_t ar,
    input  logic     r_valid,
    output logic     r_ready,
    input  axil_r_t  r,
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output bus_rsp_t rsp
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WR_REQ,
        ST_WR_RSP,
        ST_RD_REQ,
        ST_RD_RSP,
        ST_REPLY
    } state_t;

    state_t   state;
    bus_cmd_t cmd_q;
    bus_rsp_t rsp_q;
    logic     aw_done;
    logic     w_done;
    logic     aw_fire;
    logic     w_fire;

    assign q_ready   = (state == ST_IDLE);
    assign aw_valid  = (state == ST_WR_REQ) && !aw_done;
    assign w_valid   = (state == ST_WR_REQ) && !w_done;
    assign b_ready   = (state == ST_WR_RSP);
    assign ar_valid  = (state == ST_RD_REQ);
    assign r_ready   = (state == ST_RD_RSP);
    assign rsp_valid = (state == ST_REPLY);

    assign aw.addr = cmd_q.addr;
    assign w.data  = cmd_q.data;
    assign w.strb  = cmd_q.strb;
    assign ar.addr = cmd_q.addr;
    assign rsp     = rsp_q;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (q_valid) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= (q_cmd.op == OP_WRITE) ? ST_WR_REQ : ST_RD_REQ;
                    end
                end
                ST_WR_REQ: begin
                    if (aw_fire) begin
                        aw_done <= 1'b1;
                    end
                    if (w_fire) begin
                        w_done <= 1'b1;
                    end
                    if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                        state <= ST_WR_RSP; // Both channels accepted
                    end
                end
                ST_WR_RSP: if (b_valid) state <= ST_REPLY;
                ST_RD_REQ: if (ar_ready) state <= ST_RD_RSP;
                ST_RD_RSP: if (r_valid) state <= ST_REPLY;
                ST_REPLY:  if (rsp_ready) state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_valid && q_ready) begin
            cmd_q      <= q_cmd;
            rsp_q.op   <= q_cmd.op;
            rsp_q.data <= '0;
        end
        if (b_valid && b_ready) begin
            rsp_q.resp <= b.resp;
        end
        if (r_valid && r_ready) begin
            rsp_q.data <= r.data;
            rsp_q.resp <= r.resp;
        end
    end

endmodule

//--- hw/axil_regfile.sv
module axil_regfile
    import axil_pkg::*;
    import bus_cmd_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     aw_valid,
    output logic     aw_ready,
    input  axil_aw_t aw,
    input  logic     w_valid,
    output logic     w_ready,
    input  axil_w_t  w,
    output logic     b_valid,
    input  logic     b_ready,
    output axil_b_t  b,
    input  logic     ar_valid,
    output logic     ar_ready,
    input  axil_ar_t ar,
    output logic     r_valid,
    input  logic     r_ready,
    output axil_r_t  r
);

    typedef logic [$clog2(REG_COUNT)-1:0] idx_t;

    logic [DATA_W-1:0] regs [REG_COUNT];
    axil_b_t           b_q;
    axil_r_t           r_q;
    logic              wr_fire;
    logic              rd_fire;
    logic              wr_ok;
    logic              rd_ok;
    idx_t              wr_idx;
    idx_t              rd_idx;

    function automatic logic addr_ok(input logic [ADDR_W-1:0] addr);
        return (addr[1:0] == 2'b00) && (addr < ADDR_W'(REG_COUNT * 4));
    endfunction

    // Write side takes AW and W in the same cycle
    assign aw_ready = aw_valid && w_valid && !b_valid;
    assign w_ready  = aw_ready;
    assign ar_ready = !r_valid;

    assign wr_fire = aw_valid && aw_ready;
    assign rd_fire = ar_valid && ar_ready;
    assign wr_ok   = addr_ok(aw.addr);
    assign rd_ok   = addr_ok(ar.addr);
    assign wr_idx  = aw.addr[$clog2(REG_COUNT)+1:2];
    assign rd_idx  = ar.addr[$clog2(REG_COUNT)+1:2];

    assign b = b_q;
    assign r = r_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire && wr_ok) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (w.strb[i]) begin
                    regs[wr_idx][8*i +: 8] <= w.data[8*i +: 8]; // Byte lane merge
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            b_q.resp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            r_q.data <= rd_ok ? regs[rd_idx] : '0; // Bad address reads zero
            r_q.resp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

//--- hw/axil_regbus_top.sv
module axil_regbus_top
    import axil_pkg::*;
    import bus_cmd_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cmd_valid,
    output logic     cmd_ready,
    input  bus_cmd_t cmd,
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output bus_rsp_t rsp
);

    logic     q_valid;
    logic     q_ready;
    bus_cmd_t q_cmd;
    logic     aw_valid;
    logic     aw_ready;
    axil_aw_t aw;
    logic     w_valid;
    logic     w_ready;
    axil_w_t  w;
    logic     b_valid;
    logic     b_ready;
    axil_b_t  b;
    logic     ar_valid;
    logic     ar_ready;
    axil_ar_t ar;
    logic     r_valid;
    logic     r_ready;
    axil_r_t  r;

    cmd_queue queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_cmd     (q_cmd)
    );

    axil_master master_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_cmd     (q_cmd),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw        (aw),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w         (w),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b         (b),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar        (ar),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r         (r),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    axil_regfile regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r)
    );

endmodule

//--- bench/axil_regbus_assertions.sv
module axil_regbus_assertions
    import axil_pkg::*;
    import bus_cmd_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     aw_valid,
    input logic     aw_ready,
    input axil_aw_t aw,
    input logic     w_valid,
    input logic     w_ready,
    input axil_w_t  w,
    input logic     ar_valid,
    input logic     ar_ready,
    input axil_ar_t ar,
    input logic     b_ready,
    input logic     r_ready,
    input logic     rsp_valid,
    input logic     rsp_ready,
    input bus_rsp_t rsp
);

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("aw_valid dropped or aw changed before aw_ready");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("w_valid dropped or w changed before w_ready");

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("ar_valid dropped or ar changed before ar_ready");

    rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("rsp_valid dropped or rsp changed before rsp_ready");

    // Master side stays quiet while reset is held
    reset_idle: assert property (@(posedge clk)
        !rst_n |-> !(aw_valid || w_valid || ar_valid || b_ready || r_ready || rsp_valid))
        else $error("Master drives a valid or ready during reset");

endmodule

//--- bench/axil_regbus_tb.sv
module axil_regbus_tb
    import axil_pkg::*;
    import bus_cmd_pkg::*;
();

    localparam int TOTAL_CMDS = 16 + 6 + 6 + 7 + 3 * CMD_DEPTH + 300;
    localparam int WATCHDOG_CYCLES = TOTAL_CMDS * 40 + 8;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     cmd_valid;
    logic     cmd_ready;
    bus_cmd_t cmd;
    logic     rsp_valid;
    logic     rsp_ready = 1'b0;
    bus_rsp_t rsp;

    logic [DATA_W-1:0] model [REG_COUNT]; // Expected register contents
    bus_rsp_t          exp_q [$];
    bus_rsp_t          exp_rsp;
    logic              ready_level;
    logic              ready_random;
    int                checks = 0;
    int                errors = 0;
    int                misc_errors;
    int                tests_run;
    int                tests_failed;
    int                test_mark;
    int                accepted;

    axil_regbus_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    bind axil_master axil_regbus_assertions assertions_i (
        .clk(clk), .rst_n(rst_n),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
        .w_valid(w_valid), .w_ready(w_ready), .w(w),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
        .b_ready(b_ready), .r_ready(r_ready),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
    );

    always #2 clk = ~clk;

    always @(negedge clk) begin
        rsp_ready <= ready_random ? ($urandom_range(0, 1) == 1) : ready_level;
    end

    function automatic bus_cmd_t make_cmd(input bus_op_t op, input logic [ADDR_W-1:0] addr,
                                          input logic [DATA_W-1:0] data,
                                          input logic [STRB_W-1:0] strb);
        bus_cmd_t c;
        c.op   = op;
        c.addr = addr;
        c.data = data;
        c.strb = strb;
        return c;
    endfunction

    function automatic bus_cmd_t random_cmd();
        logic [ADDR_W-1:0] addr;
        bus_op_t           op;
        addr = ($urandom_range(0, 9) == 0) ? $urandom_range(0, 127) : $urandom_range(0, 15) << 2;
        op   = ($urandom_range(0, 1) == 1) ? OP_WRITE : OP_READ;
        return make_cmd(op, addr, $urandom(), STRB_W'($urandom_range(0, 15)));
    endfunction

    // Reference model, applied in command order
    function automatic bus_rsp_t predict_rsp(input bus_cmd_t c);
        bus_rsp_t   p;
        logic       hit;
        logic [3:0] idx;
        hit    = (c.addr[1:0] == 2'b00) && (c.addr <= 32'h3C);
        idx    = c.addr[5:2];
        p.op   = c.op;
        p.data = '0;
        p.resp = hit ? RESP_OKAY : RESP_SLVERR;
        if (hit && c.op == OP_WRITE) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (c.strb[i]) begin
                    model[idx][8*i +: 8] = c.data[8*i +: 8];
                end
            end
        end else if (hit) begin
            p.data = model[idx];
        end
        return p;
    endfunction

    task automatic check_rsp_data(input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: rsp.data expected %h, got %h", $time, exp, act);
        end
    endtask

    task automatic check_rsp_resp(input axil_resp_t exp, input axil_resp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: rsp.resp expected %b, got %b", $time, exp, act);
        end
    endtask

    task automatic check_rsp_op(input bus_op_t exp, input bus_op_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: rsp.op expected %b, got %b", $time, exp, act);
        end
    endtask

    // Called at a falling edge, returns at a falling edge
    task automatic push_cmd(input bus_cmd_t c);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        cmd_valid = 1'b1;
        cmd       = c;
        exp_q.push_back(predict_rsp(c));
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string name);
        int fails;
        fails = errors + misc_errors - test_mark;
        tests_run++;
        if (fails != 0) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", tests_run, name, (fails == 0) ? "ok" : "failed");
        test_mark = errors + misc_errors;
    endtask

    always @(posedge clk) begin
        if (rst_n && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Response at %0t arrived with no command outstanding", $time);
            end else begin
                exp_rsp = exp_q.pop_front();
                check_rsp_op(exp_rsp.op, rsp.op);
                check_rsp_data(exp_rsp.data, rsp.data);
                check_rsp_resp(exp_rsp.resp, rsp.resp);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h41b3_c62a));
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        ready_level  = 1'b1;
        ready_random = 1'b0;
        misc_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_mark    = 0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < REG_COUNT; i++) begin
            push_cmd(make_cmd(OP_READ, 32'(i * 4), '0, '0));
        end
        wait_drain();
        end_test("reset values");

        push_cmd(make_cmd(OP_WRITE, 32'h00, 32'hDEAD_BEEF, 4'hF));
        push_cmd(make_cmd(OP_WRITE, 32'h1C, 32'h0123_4567, 4'hF));
        push_cmd(make_cmd(OP_WRITE, 32'h3C, 32'hA5A5_5A5A, 4'hF));
        push_cmd(make_cmd(OP_READ, 32'h00, '0, '0));
        push_cmd(make_cmd(OP_READ, 32'h1C, '0, '0));
        push_cmd(make_cmd(OP_READ, 32'h3C, '0, '0));
        wait_drain();
        end_test("full-word write and read");

        push_cmd(make_cmd(OP_WRITE, 32'h0C, 32'hFFFF_FFFF, 4'hF));
        push_cmd(make_cmd(OP_WRITE, 32'h0C, 32'h1122_3344, 4'b0101));
        push_cmd(make_cmd(OP_READ, 32'h0C, '0, '0));
        push_cmd(make_cmd(OP_WRITE, 32'h0C, 32'hAABB_CCDD, 4'b1000));
        push_cmd(make_cmd(OP_WRITE, 32'h0C, 32'h0000_0000, 4'b0000)); // No lanes enabled
        push_cmd(make_cmd(OP_READ, 32'h0C, '0, '0));
        wait_drain();
        end_test("partial strobes");

        push_cmd(make_cmd(OP_WRITE, 32'h40, 32'h1234_5678, 4'hF)); // Would hit reg 0 if decoded
        push_cmd(make_cmd(OP_WRITE, 32'h06, 32'hFFFF_FFFF, 4'hF)); // Would hit reg 1 if decoded
        push_cmd(make_cmd(OP_READ, 32'h40, '0, '0));
        push_cmd(make_cmd(OP_READ, 32'h102, '0, '0));
        push_cmd(make_cmd(OP_READ, 32'hFFFF_FFFC, '0, '0));
        push_cmd(make_cmd(OP_READ, 32'h04, '0, '0));
        push_cmd(make_cmd(OP_READ, 32'h00, '0, '0));
        wait_drain();
        end_test("decode errors");

        ready_level = 1'b0;
        repeat (2) @(negedge clk);
        accepted = 0;
        while (cmd_ready && accepted < 3 * CMD_DEPTH) begin
            push_cmd(make_cmd((accepted % 2 == 1) ? OP_READ : OP_WRITE, 32'h14,
                              32'h1000_0000 + 32'(accepted), 4'hF));
            accepted++;
        end
        if (cmd_ready) begin
            misc_errors++;
            $display("cmd_ready never fell while rsp_ready was held low");
        end else if (accepted < CMD_DEPTH) begin
            misc_errors++;
            $display("Only %0d commands accepted before cmd_ready fell", accepted);
        end
        ready_level = 1'b1;
        wait_drain();
        end_test("back-pressure and ordering");

        ready_random = 1'b1;
        for (int i = 0; i < 300; i++) begin
            push_cmd(random_cmd());
        end
        ready_random = 1'b0;
        wait_drain();
        end_test("random mix");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors + misc_errors);
        if (errors + misc_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- axil_regbus.f
hw/axil_pkg.sv
hw/bus_cmd_pkg.sv
hw/cmd_queue.sv
hw/axil_master.sv
hw/axil_regfile.sv
hw/axil_regbus_top.sv
bench/axil_regbus_assertions.sv
bench/axil_regbus_tb.sv

//--- Makefile
TOP = axil_regbus_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f axil_regbus.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
